//--- hdl/qspi_pkg.sv
`default_nettype none

package qspi_pkg;

    localparam int COMM_WIDTH  = 8;
    localparam int ADDR_WIDTH  = 24;
    localparam int DATA_WIDTH  = 32;
    localparam int DIV_WIDTH   = 16;
    localparam int FRAME_WIDTH = COMM_WIDTH + ADDR_WIDTH + DATA_WIDTH;

    // serial clocks spent in the dummy phase
    localparam int DUMMY_SINGLE = 8;
    localparam int DUMMY_DUAL   = 8;
    localparam int DUMMY_QUAD   = 10;

    typedef enum logic [1:0] {
        LANE_SINGLE = 2'd0,
        LANE_DUAL   = 2'd1,
        LANE_QUAD   = 2'd2
    } lane_mode_e;

    typedef enum logic [2:0] {
        PH_IDLE    = 3'd0,
        PH_SELECT  = 3'd1,
        PH_COMMAND = 3'd2,
        PH_ADDRESS = 3'd3,
        PH_DUMMY   = 3'd4,
        PH_DATA    = 3'd5,
        PH_STOP    = 3'd6
    } phase_e;

endpackage

`default_nettype wire

//--- hdl/qspi_clock_gen.sv
`default_nettype none

module qspi_clock_gen (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_run,
    input  logic [qspi_pkg::DIV_WIDTH-1:0] i_divider,
    output logic                           o_sclk_raw,
    output logic                           o_rise,
    output logic                           o_fall
);
    import qspi_pkg::*;

    logic [DIV_WIDTH-1:0] div_cnt;
    logic [1:0]           quarter;
    logic                 tick;

    assign tick = i_run && (div_cnt == i_divider);

    // divider restarts whenever the link goes quiet
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            div_cnt <= '0;
        end else if (!i_run || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // four ticks per bit, high between tick 1 and tick 3
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            quarter    <= 2'd0;
            o_sclk_raw <= 1'b0;
            o_rise     <= 1'b0;
            o_fall     <= 1'b0;
        end else begin
            o_rise <= 1'b0;
            o_fall <= 1'b0;
            if (!i_run) begin
                quarter    <= 2'd0;
                o_sclk_raw <= 1'b0;
            end else if (tick) begin
                quarter <= quarter + 2'd1;
                if (quarter == 2'd1) begin
                    o_sclk_raw <= 1'b1;
                    o_rise     <= 1'b1;
                end
                if (quarter == 2'd3) begin
                    o_sclk_raw <= 1'b0;
                    o_fall     <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/qspi_sequencer.sv
`default_nettype none

module qspi_sequencer (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,
    input  logic                 i_rw,
    input  qspi_pkg::lane_mode_e i_mode,
    input  logic                 i_fall,
    output logic                 o_run,
    output logic                 o_load,
    output logic                 o_busy,
    output logic                 o_done,
    output logic                 o_cs_n,
    output qspi_pkg::phase_e     o_phase,
    output qspi_pkg::lane_mode_e o_lane_mode,
    output logic                 o_rw
);
    import qspi_pkg::*;

    phase_e     phase;
    phase_e     next_phase;
    lane_mode_e mode_q;
    logic       rw_q;
    logic [5:0] beat_cnt;
    logic [5:0] beat_last;
    logic [1:0] lane_shift;

    // log2 of the lane count
    always_comb begin
        case (mode_q)
            LANE_DUAL: lane_shift = 2'd1;
            LANE_QUAD: lane_shift = 2'd2;
            default:   lane_shift = 2'd0;
        endcase
    end

    always_comb begin
        case (phase)
            PH_COMMAND: beat_last = 6'(COMM_WIDTH - 1);
            PH_ADDRESS: beat_last = 6'((ADDR_WIDTH >> lane_shift) - 1);
            PH_DATA:    beat_last = 6'((DATA_WIDTH >> lane_shift) - 1);
            PH_DUMMY: begin
                case (mode_q)
                    LANE_DUAL: beat_last = 6'(DUMMY_DUAL - 1);
                    LANE_QUAD: beat_last = 6'(DUMMY_QUAD - 1);
                    default:   beat_last = 6'(DUMMY_SINGLE - 1);
                endcase
            end
            default:    beat_last = 6'd0;
        endcase
    end

    always_comb begin
        case (phase)
            PH_SELECT:  next_phase = PH_COMMAND;
            PH_COMMAND: next_phase = PH_ADDRESS;
            PH_ADDRESS: next_phase = PH_DUMMY;
            PH_DUMMY:   next_phase = PH_DATA;
            PH_DATA:    next_phase = PH_STOP;
            default:    next_phase = PH_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase    <= PH_IDLE;
            mode_q   <= LANE_SINGLE;
            rw_q     <= 1'b0;
            beat_cnt <= 6'd0;
            o_busy   <= 1'b0;
            o_done   <= 1'b0;
            o_cs_n   <= 1'b1;
        end else begin
            o_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (i_start) begin
                        phase  <= PH_SELECT;
                        mode_q <= i_mode;
                        rw_q   <= i_rw;
                        o_busy <= 1'b1;
                        o_cs_n <= 1'b0;
                    end
                end
                PH_SELECT: begin
                    phase <= next_phase;
                end
                default: begin
                    // a beat ends on the falling serial edge
                    if (i_fall) begin
                        if (beat_cnt == beat_last) begin
                            beat_cnt <= 6'd0;
                            phase    <= next_phase;
                            if (phase == PH_DATA) begin
                                o_cs_n <= 1'b1;
                            end
                            if (phase == PH_STOP) begin
                                o_busy <= 1'b0;
                                o_done <= 1'b1;
                            end
                        end else begin
                            beat_cnt <= beat_cnt + 6'd1;
                        end
                    end
                end
            endcase
        end
    end

    assign o_run       = (phase != PH_IDLE) && (phase != PH_SELECT);
    assign o_load      = (phase == PH_SELECT);
    assign o_phase     = phase;
    assign o_lane_mode = mode_q;
    assign o_rw        = rw_q;

endmodule

`default_nettype wire

//--- hdl/qspi_shifter.sv
`default_nettype none

module qspi_shifter (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_load,
    input  logic                            i_rise,
    input  logic                            i_fall,
    input  logic                            i_rw,
    input  qspi_pkg::phase_e                i_phase,
    input  qspi_pkg::lane_mode_e            i_lane_mode,
    input  logic [qspi_pkg::COMM_WIDTH-1:0] i_command,
    input  logic [qspi_pkg::ADDR_WIDTH-1:0] i_addr,
    input  logic [qspi_pkg::DATA_WIDTH-1:0] i_wdata,
    input  logic [3:0]                      i_io,
    output logic [3:0]                      o_io_out,
    output logic [3:0]                      o_io_oe,
    output logic [qspi_pkg::DATA_WIDTH-1:0] o_rdata
);
    import qspi_pkg::*;

    logic [FRAME_WIDTH-1:0] tx_q;
    logic [DATA_WIDTH-1:0]  rx_q;
    lane_mode_e             tx_mode;
    logic [3:0]             lane_mask;
    logic [3:0]             tx_lanes;
    logic                   shift_en;

    // command always goes out on io0
    assign tx_mode  = (i_phase == PH_COMMAND) ? LANE_SINGLE : i_lane_mode;
    assign shift_en = i_phase inside {PH_COMMAND, PH_ADDRESS, PH_DATA};

    always_comb begin
        case (tx_mode)
            LANE_DUAL: tx_lanes = {2'b00, tx_q[FRAME_WIDTH-1 -: 2]};
            LANE_QUAD: tx_lanes = tx_q[FRAME_WIDTH-1 -: 4];
            default:   tx_lanes = {3'b000, tx_q[FRAME_WIDTH-1]};
        endcase
        case (i_lane_mode)
            LANE_DUAL: lane_mask = 4'b0011;
            LANE_QUAD: lane_mask = 4'b1111;
            default:   lane_mask = 4'b0001;
        endcase
    end

    always_comb begin
        case (i_phase)
            PH_COMMAND: o_io_oe = 4'b0001;
            PH_ADDRESS: o_io_oe = lane_mask;
            PH_DATA:    o_io_oe = i_rw ? 4'b0000 : lane_mask;
            default:    o_io_oe = 4'b0000;
        endcase
    end

    assign o_io_out = tx_lanes & o_io_oe;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_q <= '0;
        end else if (i_load) begin
            tx_q <= {i_command, i_addr, i_wdata};
        end else if (i_fall && shift_en) begin
            case (tx_mode)
                LANE_DUAL: tx_q <= {tx_q[FRAME_WIDTH-3:0], 2'b00};
                LANE_QUAD: tx_q <= {tx_q[FRAME_WIDTH-5:0], 4'b0000};
                default:   tx_q <= {tx_q[FRAME_WIDTH-2:0], 1'b0};
            endcase
        end
    end

    // single mode reads back on io1
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_q <= '0;
        end else if (i_rise && i_rw && (i_phase == PH_DATA)) begin
            case (i_lane_mode)
                LANE_DUAL: rx_q <= {rx_q[DATA_WIDTH-3:0], i_io[1:0]};
                LANE_QUAD: rx_q <= {rx_q[DATA_WIDTH-5:0], i_io[3:0]};
                default:   rx_q <= {rx_q[DATA_WIDTH-2:0], i_io[1]};
            endcase
        end
    end

    assign o_rdata = rx_q;

endmodule

`default_nettype wire

//--- hdl/qspi_master.sv
`default_nettype none

module qspi_master (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_start,
    input  logic                            i_rw,
    input  qspi_pkg::lane_mode_e            i_mode,
    input  logic                            i_cpol,
    input  logic [qspi_pkg::DIV_WIDTH-1:0]  i_divider,
    input  logic [qspi_pkg::COMM_WIDTH-1:0] i_command,
    input  logic [qspi_pkg::ADDR_WIDTH-1:0] i_addr,
    input  logic [qspi_pkg::DATA_WIDTH-1:0] i_wdata,
    input  logic [3:0]                      i_io,
    output logic                            o_sclk,
    output logic                            o_cs_n,
    output logic [3:0]                      o_io_out,
    output logic [3:0]                      o_io_oe,
    output logic [qspi_pkg::DATA_WIDTH-1:0] o_rdata,
    output logic                            o_busy,
    output logic                            o_done
);
    import qspi_pkg::*;

    logic       run;
    logic       load;
    logic       sclk_raw;
    logic       rise;
    logic       fall;
    logic       rw;
    logic       cpol_q;
    phase_e     phase;
    lane_mode_e lane_mode;

    // polarity is taken with the start pulse
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cpol_q <= 1'b0;
        end else if (i_start && !o_busy) begin
            cpol_q <= i_cpol;
        end
    end

    // no serial clock pulses while deselected, e.g. during stop
    assign o_sclk = (sclk_raw & ~o_cs_n) ^ cpol_q;

    qspi_clock_gen u_clock_gen (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_run      (run),
        .i_divider  (i_divider),
        .o_sclk_raw (sclk_raw),
        .o_rise     (rise),
        .o_fall     (fall)
    );

    qspi_sequencer u_sequencer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_rw        (i_rw),
        .i_mode      (i_mode),
        .i_fall      (fall),
        .o_run       (run),
        .o_load      (load),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_cs_n      (o_cs_n),
        .o_phase     (phase),
        .o_lane_mode (lane_mode),
        .o_rw        (rw)
    );

    qspi_shifter u_shifter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load      (load),
        .i_rise      (rise),
        .i_fall      (fall),
        .i_rw        (rw),
        .i_phase     (phase),
        .i_lane_mode (lane_mode),
        .i_command   (i_command),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_io        (i_io),
        .o_io_out    (o_io_out),
        .o_io_oe     (o_io_oe),
        .o_rdata     (o_rdata)
    );

endmodule

`default_nettype wire

//--- testbench/qspi_flash_model.sv
`default_nettype none

module qspi_flash_model (
    input  logic                            i_sclk,
    input  logic                            i_cs_n,
    input  logic [3:0]                      i_io_out,
    input  logic [3:0]                      i_io_oe,
    input  qspi_pkg::lane_mode_e            i_mode,
    input  logic                            i_cpol,
    output logic [3:0]                      o_io,
    output logic [qspi_pkg::COMM_WIDTH-1:0] o_command,
    output logic [qspi_pkg::ADDR_WIDTH-1:0] o_addr,
    output logic [qspi_pkg::DATA_WIDTH-1:0] o_wdata,
    output int                              o_write_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import qspi_pkg::*;

    localparam logic [DATA_WIDTH-1:0] READ_KEY = 32'ha5c3_0f96;

    logic                  sclk_raw;
    int                    lanes;
    int                    dummy;
    int                    addr_end;
    int                    data_first;
    int                    data_end;
    int                    beat = 0;
    int                    writes = 0;
    logic [DATA_WIDTH-1:0] cmd_sr = '0;
    logic [DATA_WIDTH-1:0] addr_sr = '0;
    logic [DATA_WIDTH-1:0] data_sr = '0;
    logic [DATA_WIDTH-1:0] rest;
    logic [3:0]            drive_q = 4'h0;

    // shift one beat of lanes in, highest lane first
    function automatic logic [DATA_WIDTH-1:0] take_lanes(input logic [DATA_WIDTH-1:0] sr,
                                                         input logic [3:0] io,
                                                         input lane_mode_e lane_mode);
        case (lane_mode)
            LANE_DUAL: return {sr[DATA_WIDTH-3:0], io[1:0]};
            LANE_QUAD: return {sr[DATA_WIDTH-5:0], io};
            default:   return {sr[DATA_WIDTH-2:0], io[0]};
        endcase
    endfunction

    assign sclk_raw = i_sclk ^ i_cpol;

    // beat boundaries of the frame for the current mode
    always_comb begin
        case (i_mode)
            LANE_DUAL: begin
                lanes = 2;
                dummy = DUMMY_DUAL;
            end
            LANE_QUAD: begin
                lanes = 4;
                dummy = DUMMY_QUAD;
            end
            default: begin
                lanes = 1;
                dummy = DUMMY_SINGLE;
            end
        endcase
        addr_end   = COMM_WIDTH + ADDR_WIDTH / lanes;
        data_first = addr_end + dummy;
        data_end   = data_first + DATA_WIDTH / lanes;
    end

    // master data is stable on the rising edge
    always @(posedge sclk_raw or posedge i_cs_n) begin
        if (i_cs_n) begin
            beat <= 0;
        end else begin
            beat <= beat + 1;
            if (beat < COMM_WIDTH) begin
                cmd_sr <= take_lanes(cmd_sr, i_io_out, LANE_SINGLE);
            end else if (beat < addr_end) begin
                addr_sr <= take_lanes(addr_sr, i_io_out, i_mode);
            end else if (beat >= data_first && beat < data_end && i_io_oe[0]) begin
                data_sr <= take_lanes(data_sr, i_io_out, i_mode);
                if (beat == data_end - 1) begin
                    writes <= writes + 1;
                end
            end
        end
    end

    // read data launched on the falling edge
    always @(negedge sclk_raw or posedge i_cs_n) begin
        if (i_cs_n || beat < data_first || beat >= data_end) begin
            drive_q <= 4'h0;
        end else begin
            rest = (DATA_WIDTH'(o_addr) ^ READ_KEY) << ((beat - data_first) * lanes);
            case (i_mode)
                LANE_DUAL: drive_q <= {2'b00, rest[DATA_WIDTH-1 -: 2]};
                LANE_QUAD: drive_q <= rest[DATA_WIDTH-1 -: 4];
                default:   drive_q <= {2'b00, rest[DATA_WIDTH-1], 1'b0};
            endcase
        end
    end

    assign o_io          = drive_q;
    assign o_command     = cmd_sr[COMM_WIDTH-1:0];
    assign o_addr        = addr_sr[ADDR_WIDTH-1:0];
    assign o_wdata       = data_sr;
    assign o_write_count = writes;

endmodule

`default_nettype wire

//--- testbench/qspi_master_props.sv
`default_nettype none

module qspi_master_props (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       i_cs_n,
    input logic [3:0] i_io_oe,
    input logic       i_busy,
    input logic       i_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // lanes float while the flash is deselected
    lanes_quiet_deselected: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cs_n |-> (i_io_oe == 4'h0))
        else begin
            fail_count = fail_count + 1;
            $error("lane output enable set while chip select is high");
        end

    busy_done_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_busy && i_done))
        else begin
            fail_count = fail_count + 1;
            $error("busy and done high in the same cycle");
        end

    done_single_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |=> !i_done)
        else begin
            fail_count = fail_count + 1;
            $error("done held for more than one cycle");
        end

endmodule

bind qspi_master qspi_master_props u_props (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_cs_n  (o_cs_n),
    .i_io_oe (o_io_oe),
    .i_busy  (o_busy),
    .i_done  (o_done)
);

`default_nettype wire

//--- testbench/tb_qspi_master.sv
`default_nettype none

module tb_qspi_master;
    timeunit 1ns;
    timeprecision 1ps;
    import qspi_pkg::*;

    localparam logic [DATA_WIDTH-1:0] READ_KEY = 32'ha5c3_0f96;
    localparam int DONE_TIMEOUT = 5000;
    localparam int IDLE_GAP     = 8;
    localparam int BUSY_RESTART = 40;

    typedef struct packed {
        logic                  rw;
        lane_mode_e            mode;
        logic                  cpol;
        logic [DIV_WIDTH-1:0]  divider;
        logic [COMM_WIDTH-1:0] command;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [DATA_WIDTH-1:0] expected;
        logic                  restart;
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start;
    logic                  rw;
    lane_mode_e            mode;
    logic                  cpol;
    logic [DIV_WIDTH-1:0]  divider;
    logic [COMM_WIDTH-1:0] command;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [3:0]            io_in;
    logic                  sclk;
    logic                  cs_n;
    logic [3:0]            io_out;
    logic [3:0]            io_oe;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  busy;
    logic                  done;
    logic [COMM_WIDTH-1:0] seen_command;
    logic [ADDR_WIDTH-1:0] seen_addr;
    logic [DATA_WIDTH-1:0] seen_wdata;
    int                    seen_writes;
    int                    seed = 32'hfaf5;
    row_t                  rows[$];

    always #4 clk = ~clk;

    qspi_master dut (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_start   (start),
        .i_rw      (rw),
        .i_mode    (mode),
        .i_cpol    (cpol),
        .i_divider (divider),
        .i_command (command),
        .i_addr    (addr),
        .i_wdata   (wdata),
        .i_io      (io_in),
        .o_sclk    (sclk),
        .o_cs_n    (cs_n),
        .o_io_out  (io_out),
        .o_io_oe   (io_oe),
        .o_rdata   (rdata),
        .o_busy    (busy),
        .o_done    (done)
    );

    qspi_flash_model flash (
        .i_sclk        (sclk),
        .i_cs_n        (cs_n),
        .i_io_out      (io_out),
        .i_io_oe       (io_oe),
        .i_mode        (mode),
        .i_cpol        (cpol),
        .o_io          (io_in),
        .o_command     (seen_command),
        .o_addr        (seen_addr),
        .o_wdata       (seen_wdata),
        .o_write_count (seen_writes)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_lanes(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic add_row(input logic row_rw, input lane_mode_e row_mode, input logic row_cpol,
                           input logic [DIV_WIDTH-1:0] row_div,
                           input logic [COMM_WIDTH-1:0] row_cmd, input logic row_restart);
        row_t r;
        r.rw       = row_rw;
        r.mode     = row_mode;
        r.cpol     = row_cpol;
        r.divider  = row_div;
        r.command  = row_cmd;
        r.restart  = row_restart;
        r.addr     = ADDR_WIDTH'($random(seed));
        r.wdata    = DATA_WIDTH'($random(seed));
        // flash answers with the address folded into a fixed key
        r.expected = row_rw ? (DATA_WIDTH'(r.addr) ^ READ_KEY) : r.wdata;
        rows.push_back(r);
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   cycles;
        int   writes_before;
        r             = rows[idx];
        writes_before = seen_writes;
        rw            = r.rw;
        mode          = r.mode;
        cpol          = r.cpol;
        divider       = r.divider;
        command       = r.command;
        addr          = r.addr;
        wdata         = r.wdata;
        start         = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("o_busy", busy, 1'b1);
        cycles = 0;
        while (!done) begin
            if (cs_n) begin
                check_bit("o_sclk", sclk, r.cpol);
            end
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                abort_run($sformatf("no o_done within %0d cycles on row %0d", DONE_TIMEOUT, idx));
            end
            // a second start mid-frame with other inputs must be ignored
            start = r.restart && (cycles == BUSY_RESTART);
            rw    = start ? ~r.rw : r.rw;
            addr  = start ? ~r.addr : r.addr;
            @(negedge clk);
        end
        check_bit("o_busy", busy, 1'b0);
        repeat (IDLE_GAP) begin
            @(negedge clk);
            check_bit("o_done", done, 1'b0);
            check_bit("o_busy", busy, 1'b0);
            check_bit("o_cs_n", cs_n, 1'b1);
            check_bit("o_sclk", sclk, r.cpol);
            check_lanes("o_io_oe", io_oe, 4'h0);
        end
        check_word("flash command", DATA_WIDTH'(seen_command), DATA_WIDTH'(r.command));
        check_word("flash address", DATA_WIDTH'(seen_addr), DATA_WIDTH'(r.addr));
        if (r.rw) begin
            check_word("o_rdata", rdata, r.expected);
            check_word("flash write count", seen_writes, writes_before);
        end else begin
            check_word("flash write data", seen_wdata, r.expected);
            check_word("flash write count", seen_writes, writes_before + 1);
        end
    endtask

    always @(negedge clk) begin
        if (dut.u_props.fail_count != 0) begin
            abort_run("a bound assertion on the DUT pins failed");
        end
    end

    initial begin
        rst_n   = 1'b0;
        start   = 1'b0;
        rw      = 1'b0;
        mode    = LANE_SINGLE;
        cpol    = 1'b0;
        divider = '0;
        command = '0;
        addr    = '0;
        wdata   = '0;
        // rw, mode, cpol, divider, command, restart
        add_row(1'b1, LANE_SINGLE, 1'b0, 16'd1, 8'h03, 1'b0);
        add_row(1'b1, LANE_DUAL,   1'b0, 16'd0, 8'h3b, 1'b0);
        add_row(1'b1, LANE_DUAL,   1'b0, 16'd2, 8'h3b, 1'b0);
        add_row(1'b1, LANE_QUAD,   1'b0, 16'd0, 8'h6b, 1'b0);
        add_row(1'b1, LANE_QUAD,   1'b0, 16'd2, 8'h6b, 1'b0);
        add_row(1'b0, LANE_SINGLE, 1'b0, 16'd1, 8'h02, 1'b0);
        add_row(1'b0, LANE_DUAL,   1'b0, 16'd0, 8'ha2, 1'b0);
        add_row(1'b0, LANE_QUAD,   1'b0, 16'd2, 8'h32, 1'b0);
        add_row(1'b1, LANE_SINGLE, 1'b1, 16'd1, 8'h03, 1'b0);
        add_row(1'b1, LANE_QUAD,   1'b1, 16'd0, 8'h6b, 1'b1);
        add_row(1'b0, LANE_DUAL,   1'b0, 16'd1, 8'ha2, 1'b1);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("o_cs_n", cs_n, 1'b1);
        check_bit("o_busy", busy, 1'b0);
        check_bit("o_done", done, 1'b0);
        check_bit("o_sclk", sclk, 1'b0);
        check_lanes("o_io_oe", io_oe, 4'h0);
        foreach (rows[i]) begin
            run_row(i);
        end
        if (dut.u_props.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run("a bound assertion on the DUT pins failed");
        end
    end

endmodule

`default_nettype wire

//--- src.f
hdl/qspi_pkg.sv
hdl/qspi_clock_gen.sv
hdl/qspi_sequencer.sv
hdl/qspi_shifter.sv
hdl/qspi_master.sv
testbench/qspi_flash_model.sv
testbench/qspi_master_props.sv
testbench/tb_qspi_master.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the QSPI master testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_qspi_master -Mdir obj_dir -o tb_qspi_master -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_qspi_master +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
